/* Makefile */
TOP = tb_core_bridge

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST OK"

clean:
	rm -rf obj_dir

/* all.f */
logic/bridge_pkg.sv
logic/reset_sequencer.sv
logic/token_arbiter.sv
logic/thread_launcher.sv
logic/msg_router.sv
logic/bus_gate.sv
logic/core_bridge.sv
verif/tb_core_bridge.sv
verif/core_bridge_props.sv

/* logic/bridge_pkg.sv */
`default_nettype none

package bridge_pkg;

  // word width for addresses, data and core indices
  localparam int data_w  = 32;
  localparam int state_w = 6;
  localparam int msg_w   = 4;

  typedef logic [data_w-1:0]  addr_t;
  typedef logic [data_w-1:0]  data_t;
  // bit 31 active flag, bits 30..0 core number
  typedef logic [data_w-1:0]  cpu_index_t;
  typedef logic [state_w-1:0] core_state_t;
  typedef logic [msg_w-1:0]   cpu_msg_t;
  typedef logic [1:0]         ind_rel_t;

  // core phases the bridge reacts to
  localparam core_state_t wait_for_start = 6'd0;
  localparam core_state_t alu_begin      = 6'd1;
  localparam core_state_t finish_begin   = 6'd2;
  localparam core_state_t finish_end     = 6'd3;

  // read class
  localparam core_state_t read_cond        = 6'd4;
  localparam core_state_t read_cond_p      = 6'd5;
  localparam core_state_t read_src1        = 6'd6;
  localparam core_state_t read_src1_p      = 6'd7;
  localparam core_state_t read_src0        = 6'd8;
  localparam core_state_t read_src0_p      = 6'd9;
  localparam core_state_t read_dst         = 6'd10;
  localparam core_state_t read_dst_p       = 6'd11;
  localparam core_state_t start_read_cmd   = 6'd12;
  localparam core_state_t start_read_cmd_p = 6'd13;
  localparam core_state_t read_mem_size_1  = 6'd14;

  // write class
  localparam core_state_t write_reg_ip = 6'd16;
  localparam core_state_t write_dst    = 6'd17;
  localparam core_state_t write_dst_p  = 6'd18;
  localparam core_state_t write_src1   = 6'd19;
  localparam core_state_t write_src0   = 6'd20;
  localparam core_state_t write_cond   = 6'd21;

  // inter-core message codes
  localparam cpu_msg_t msg_none      = 4'd0;
  localparam cpu_msg_t msg_reset     = 4'd1;
  localparam cpu_msg_t msg_start     = 4'd2;
  localparam cpu_msg_t msg_end       = 4'd3;
  localparam cpu_msg_t msg_fork_thrd = 4'd4;
  localparam cpu_msg_t msg_stop_thrd = 4'd5;
  localparam cpu_msg_t msg_fork_done = 4'd6;
  localparam cpu_msg_t msg_stop_done = 4'd7;

  // thread header sits in front of code and data
  localparam addr_t thread_header_space = 32'd16;

  // called index relative to own index
  localparam ind_rel_t rel_none    = 2'd0;
  localparam ind_rel_t rel_less    = 2'd1;
  localparam ind_rel_t rel_greater = 2'd2;
  localparam ind_rel_t rel_equal   = 2'd3;

endpackage

`default_nettype wire

/* logic/bus_gate.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_gate (
  input  logic                    clk,
  input  logic                    ext_rst_b,
  input  logic                    seq_ready,
  input  logic                    online,
  input  logic                    read_q,
  input  logic                    write_q,
  input  bridge_pkg::core_state_t state,
  output logic                    ext_read_q,
  output logic                    ext_write_q,
  output logic                    ext_dispatcher_q
);

  logic is_read;
  logic is_write;

  // phase class decode
  always_comb begin
    is_read  = 1'b0;
    is_write = 1'b0;
    case (state)
      bridge_pkg::read_cond, bridge_pkg::read_cond_p,
      bridge_pkg::read_src1, bridge_pkg::read_src1_p,
      bridge_pkg::read_src0, bridge_pkg::read_src0_p,
      bridge_pkg::read_dst, bridge_pkg::read_dst_p,
      bridge_pkg::start_read_cmd, bridge_pkg::start_read_cmd_p,
      bridge_pkg::read_mem_size_1: begin
        is_read = 1'b1;
      end
      bridge_pkg::write_reg_ip, bridge_pkg::write_dst,
      bridge_pkg::write_dst_p, bridge_pkg::write_src1,
      bridge_pkg::write_src0, bridge_pkg::write_cond: begin
        is_write = 1'b1;
      end
      default: begin
        is_read  = 1'b0;
        is_write = 1'b0;
      end
    endcase
  end

  // requests reach the bus only with the token held
  assign ext_read_q  = online && is_read && read_q;
  assign ext_write_q = online && is_write && write_q;

  // dispatcher sees a memory phase one cycle late
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      ext_dispatcher_q <= 1'b0;
    end else begin
      ext_dispatcher_q <= seq_ready && (is_read || is_write);
    end
  end

endmodule

`default_nettype wire

/* logic/core_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

module core_bridge (
  input  logic                    clk,
  input  logic                    ext_rst_b,
  input  bridge_pkg::core_state_t state,
  input  bridge_pkg::addr_t       addr_in,
  input  bridge_pkg::data_t       data_in,
  input  logic                    read_q,
  input  logic                    write_q,
  input  logic                    bus_busy_in,
  input  bridge_pkg::cpu_index_t  ext_cpu_index,
  input  logic                    ext_next_cpu_q,
  input  bridge_pkg::cpu_msg_t    ext_cpu_msg_in,
  input  bridge_pkg::cpu_msg_t    int_cpu_msg_in,
  output bridge_pkg::addr_t       base_addr,
  output bridge_pkg::addr_t       base_addr_data,
  output bridge_pkg::ind_rel_t    cpu_ind_rel,
  output logic                    bus_busy_out,
  output logic                    disp_online,
  output logic                    next_state,
  output logic                    rst,
  output logic                    ext_rst_e,
  output logic                    ext_next_cpu_e,
  output logic                    ext_dispatcher_q,
  output bridge_pkg::cpu_msg_t    int_cpu_msg_out,
  output bridge_pkg::cpu_msg_t    ext_cpu_msg,
  output logic                    ext_read_q,
  output logic                    ext_write_q
);

  logic                   seq_ready;
  bridge_pkg::cpu_index_t my_index;
  logic                   reset_announce;
  logic                   grant;
  logic                   thread_step;
  bridge_pkg::cpu_msg_t   thread_msg;
  logic                   done_seen;

  // index capture and reset pulses
  reset_sequencer u_reset_sequencer (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .state          (state),
    .ext_cpu_index  (ext_cpu_index),
    .grant          (grant),
    .seq_ready      (seq_ready),
    .my_index       (my_index),
    .reset_announce (reset_announce),
    .rst            (rst),
    .ext_rst_e      (ext_rst_e),
    .bus_busy_out   (bus_busy_out)
  );

  // token ownership and release
  token_arbiter u_token_arbiter (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .seq_ready      (seq_ready),
    .my_index       (my_index),
    .ext_cpu_index  (ext_cpu_index),
    .ext_next_cpu_q (ext_next_cpu_q),
    .bus_busy_in    (bus_busy_in),
    .read_q         (read_q),
    .write_q        (write_q),
    .thread_step    (thread_step),
    .done_seen      (done_seen),
    .state          (state),
    .grant          (grant),
    .online         (disp_online),
    .ext_next_cpu_e (ext_next_cpu_e),
    .cpu_ind_rel    (cpu_ind_rel)
  );

  thread_launcher u_thread_launcher (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .grant          (grant),
    .state          (state),
    .addr_in        (addr_in),
    .data_in        (data_in),
    .thread_step    (thread_step),
    .thread_msg     (thread_msg),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .next_state     (next_state)
  );

  msg_router u_msg_router (
    .clk             (clk),
    .ext_rst_b       (ext_rst_b),
    .reset_announce  (reset_announce),
    .thread_msg      (thread_msg),
    .int_cpu_msg_in  (int_cpu_msg_in),
    .ext_cpu_msg_in  (ext_cpu_msg_in),
    .ext_cpu_msg     (ext_cpu_msg),
    .int_cpu_msg_out (int_cpu_msg_out),
    .done_seen       (done_seen)
  );

  // memory request gating
  bus_gate u_bus_gate (
    .clk              (clk),
    .ext_rst_b        (ext_rst_b),
    .seq_ready        (seq_ready),
    .online           (disp_online),
    .read_q           (read_q),
    .write_q          (write_q),
    .state            (state),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q),
    .ext_dispatcher_q (ext_dispatcher_q)
  );

endmodule

`default_nettype wire

/* logic/msg_router.sv */
`timescale 1ns/100ps
`default_nettype none

module msg_router (
  input  logic                 clk,
  input  logic                 ext_rst_b,
  input  logic                 reset_announce,
  input  bridge_pkg::cpu_msg_t thread_msg,
  input  bridge_pkg::cpu_msg_t int_cpu_msg_in,
  input  bridge_pkg::cpu_msg_t ext_cpu_msg_in,
  output bridge_pkg::cpu_msg_t ext_cpu_msg,
  output bridge_pkg::cpu_msg_t int_cpu_msg_out,
  output logic                 done_seen
);

  bridge_pkg::cpu_msg_t msg_q;

  // own message lives one cycle only
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      msg_q <= bridge_pkg::msg_none;
    end else if (reset_announce) begin
      msg_q <= bridge_pkg::msg_reset;
    end else if (thread_msg != bridge_pkg::msg_none) begin
      msg_q <= thread_msg;
    end else begin
      msg_q <= bridge_pkg::msg_none;
    end
  end

  // core fork and stop requests bypass the register
  assign ext_cpu_msg = (int_cpu_msg_in == bridge_pkg::msg_fork_thrd ||
                        int_cpu_msg_in == bridge_pkg::msg_stop_thrd) ? int_cpu_msg_in : msg_q;

  // only completions reach the core
  assign int_cpu_msg_out = (ext_cpu_msg_in == bridge_pkg::msg_fork_done ||
                            ext_cpu_msg_in == bridge_pkg::msg_stop_done) ? ext_cpu_msg_in
                                                                        : bridge_pkg::msg_none;

  assign done_seen = (int_cpu_msg_out != bridge_pkg::msg_none);

endmodule

`default_nettype wire

/* logic/reset_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module reset_sequencer (
  input  logic                    clk,
  input  logic                    ext_rst_b,
  input  bridge_pkg::core_state_t state,
  input  bridge_pkg::cpu_index_t  ext_cpu_index,
  input  logic                    grant,
  output logic                    seq_ready,
  output bridge_pkg::cpu_index_t  my_index,
  output logic                    reset_announce,
  output logic                    rst,
  output logic                    ext_rst_e,
  output logic                    bus_busy_out
);

  // arm is only passed once, right after the external reset
  typedef enum logic [2:0] {
    st_arm,
    st_capture,
    st_pulse,
    st_settle,
    st_run
  } step_t;

  step_t step;

  // message register picks this up on the capture edge
  assign reset_announce = (step == st_capture);

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      step         <= st_arm;
      seq_ready    <= 1'b0;
      my_index     <= '0;
      rst          <= 1'b0;
      ext_rst_e    <= 1'b0;
      bus_busy_out <= 1'b0;
    end else begin
      // pulses default low, one cycle wide
      rst          <= 1'b0;
      ext_rst_e    <= 1'b0;
      bus_busy_out <= 1'b0;
      case (step)
        st_arm: begin
          step <= st_capture;
        end
        st_capture: begin
          // index as seen on the shared bus right now
          my_index <= ext_cpu_index;
          step     <= st_pulse;
        end
        st_pulse: begin
          // core and outside reset, bus held busy meanwhile
          rst          <= 1'b1;
          ext_rst_e    <= 1'b1;
          bus_busy_out <= 1'b1;
          step         <= st_settle;
        end
        st_settle: begin
          seq_ready <= 1'b1;
          step      <= st_run;
        end
        st_run: begin
          // core done and not holding the token, go again
          if (state == bridge_pkg::finish_end && !grant) begin
            seq_ready <= 1'b0;
            step      <= st_capture;
          end
        end
        default: begin
          step <= st_arm;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/thread_launcher.sv */
`timescale 1ns/100ps
`default_nettype none

module thread_launcher (
  input  logic                    clk,
  input  logic                    ext_rst_b,
  input  logic                    grant,
  input  bridge_pkg::core_state_t state,
  input  bridge_pkg::addr_t       addr_in,
  input  bridge_pkg::addr_t       data_in,
  output logic                    thread_step,
  output bridge_pkg::cpu_msg_t    thread_msg,
  output bridge_pkg::addr_t       base_addr,
  output bridge_pkg::addr_t       base_addr_data,
  output logic                    next_state
);

  logic              is_start;
  logic              is_finish;
  bridge_pkg::addr_t code_base;
  bridge_pkg::addr_t data_base;

  assign is_start    = grant && (state == bridge_pkg::wait_for_start);
  assign is_finish   = grant && (state == bridge_pkg::finish_begin);
  assign thread_step = is_start || is_finish;

  // code and data start behind the header
  assign code_base = addr_in + bridge_pkg::thread_header_space;
  // no separate data segment, data shares the code base
  assign data_base = (data_in == '0) ? code_base
                                     : data_in + bridge_pkg::thread_header_space;

  always_comb begin
    if (is_start) begin
      thread_msg = bridge_pkg::msg_start;
    end else if (is_finish) begin
      thread_msg = bridge_pkg::msg_end;
    end else begin
      thread_msg = bridge_pkg::msg_none;
    end
  end

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      next_state     <= 1'b0;
      base_addr      <= '0;
      base_addr_data <= '0;
    end else begin
      // core advances one phase
      next_state <= thread_step;
      // finish keeps the old bases
      if (is_start) begin
        base_addr      <= code_base;
        base_addr_data <= data_base;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/token_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module token_arbiter (
  input  logic                    clk,
  input  logic                    ext_rst_b,
  input  logic                    seq_ready,
  input  bridge_pkg::cpu_index_t  my_index,
  input  bridge_pkg::cpu_index_t  ext_cpu_index,
  input  logic                    ext_next_cpu_q,
  input  logic                    bus_busy_in,
  input  logic                    read_q,
  input  logic                    write_q,
  input  logic                    thread_step,
  input  logic                    done_seen,
  input  bridge_pkg::core_state_t state,
  output logic                    grant,
  output logic                    online,
  output logic                    ext_next_cpu_e,
  output bridge_pkg::ind_rel_t    cpu_ind_rel
);

  logic                 release_cause;
  bridge_pkg::ind_rel_t rel_next;

  // own index called while the query is up
  assign grant = seq_ready && ext_next_cpu_q && (ext_cpu_index == my_index);

  // busy bus holds off every release, request levels stay up
  always_comb begin
    release_cause = 1'b0;
    if (!bus_busy_in) begin
      release_cause = thread_step
                   || (online && (read_q || write_q))
                   || (state == bridge_pkg::alu_begin && done_seen && !grant);
    end
  end

  // active flag takes no part in the ordering
  always_comb begin
    if (ext_cpu_index == my_index) begin
      rel_next = bridge_pkg::rel_equal;
    end else if (ext_cpu_index[30:0] < my_index[30:0]) begin
      rel_next = bridge_pkg::rel_less;
    end else if (ext_cpu_index[30:0] > my_index[30:0]) begin
      rel_next = bridge_pkg::rel_greater;
    end else begin
      // same number, other flag
      rel_next = bridge_pkg::rel_none;
    end
  end

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      online         <= 1'b0;
      ext_next_cpu_e <= 1'b0;
      cpu_ind_rel    <= bridge_pkg::rel_none;
    end else begin
      // single-cycle release, never back to back
      ext_next_cpu_e <= release_cause && !ext_next_cpu_e;
      // release wins over a grant still on the bus
      if (ext_next_cpu_e) begin
        online <= 1'b0;
      end else if (grant && !bus_busy_in) begin
        online <= 1'b1;
      end
      if (ext_next_cpu_q && seq_ready) begin
        cpu_ind_rel <= rel_next;
      end else if (ext_next_cpu_e) begin
        cpu_ind_rel <= bridge_pkg::rel_none;
      end
    end
  end

endmodule

`default_nettype wire

/* verif/bridge_tests.txt */
# kind state addr data rq wq busy index nextq extmsg intmsg then expected: msg imsg rel nxte online nxtst rst disp rdq wrq
# kind 0 plain, 1 launch with random addr (random data if data nonzero), 2 random foreign index
0 3f 0 0 0 0 0 80000010 0 0 0  0 0 0 0 0 0 0 0 0 0
0 3f 0 0 0 0 0 80000010 0 0 0  1 0 0 0 0 0 0 0 0 0
0 3f 0 0 0 0 0 80000010 0 0 0  0 0 0 0 0 0 1 0 0 0
0 3f 0 0 0 0 0 80000010 0 0 0  0 0 0 0 0 0 0 0 0 0
0 3f 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0
2 3f 0 0 0 0 0 0 1 0 0  0 0 0 0 0 0 0 0 0 0
0 3f 0 0 0 0 0 80000005 1 0 0  0 0 1 0 0 0 0 0 0 0
0 3f 0 0 0 0 0 00000030 1 0 0  0 0 2 0 0 0 0 0 0 0
1 0 0 0 0 0 0 80000010 1 0 0  2 0 3 1 1 1 0 0 0 0
0 3f 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0
1 0 0 1 0 0 0 80000010 1 0 0  2 0 3 1 1 1 0 0 0 0
0 3f 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0
0 4 0 0 0 0 0 80000010 1 0 0  0 0 3 0 1 0 0 1 0 0
0 4 0 0 1 0 0 0 0 0 0  0 0 3 1 1 0 0 1 1 0
0 4 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 1 0 0
0 11 0 0 0 0 0 80000010 1 0 0  0 0 3 0 1 0 0 1 0 0
0 11 0 0 1 1 1 0 0 0 0  0 0 3 0 1 0 0 1 0 1
0 11 0 0 1 1 1 0 0 0 0  0 0 3 0 1 0 0 1 0 1
0 11 0 0 1 1 0 0 0 0 0  0 0 3 1 1 0 0 1 0 1
0 11 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 1 0 0
0 3f 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0
0 3f 0 0 0 0 0 0 0 6 4  4 6 0 0 0 0 0 0 0 0
0 3f 0 0 0 0 0 0 0 7 5  5 7 0 0 0 0 0 0 0 0
0 3f 0 0 0 0 0 0 0 2 2  0 0 0 0 0 0 0 0 0 0
0 1 0 0 0 0 0 0 0 6 0  0 6 0 1 0 0 0 0 0 0
0 3f 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0
0 2 0 0 0 0 0 80000010 1 0 0  3 0 3 1 1 1 0 0 0 0
0 3 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0
0 3f 0 0 0 0 0 80000010 0 0 0  1 0 0 0 0 0 0 0 0 0
0 3f 0 0 0 0 0 80000010 0 0 0  0 0 0 0 0 0 1 0 0 0
0 3f 0 0 0 0 0 80000010 0 0 0  0 0 0 0 0 0 0 0 0 0
0 3f 0 0 0 0 0 80000010 1 0 0  0 0 3 0 1 0 0 0 0 0
0 3f 0 0 0 0 0 0 0 0 0  0 0 3 0 1 0 0 0 0 0

/* verif/core_bridge_props.sv */
`timescale 1ns/100ps
`default_nettype none

module core_bridge_props (
  input logic clk,
  input logic ext_rst_b,
  input logic ext_next_cpu_e,
  input logic ext_read_q,
  input logic disp_online,
  input logic rst,
  input logic ext_rst_e
);

  // token release is a single pulse
  assert property (@(posedge clk) disable iff (ext_rst_b)
                   ext_next_cpu_e |=> !ext_next_cpu_e)
    else $error("ext_next_cpu_e high for two cycles");

  // reads only reach the bus while online
  assert property (@(posedge clk) disable iff (ext_rst_b)
                   ext_read_q |-> disp_online)
    else $error("ext_read_q without disp_online");

  // outside reset mirrors the core reset
  assert property (@(posedge clk) ext_rst_e == rst)
    else $error("ext_rst_e and rst differ");

endmodule

bind core_bridge core_bridge_props u_props (
  .clk            (clk),
  .ext_rst_b      (ext_rst_b),
  .ext_next_cpu_e (ext_next_cpu_e),
  .ext_read_q     (ext_read_q),
  .disp_online    (disp_online),
  .rst            (rst),
  .ext_rst_e      (ext_rst_e)
);

`default_nettype wire

/* verif/tb_core_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_core_bridge;

  localparam int max_lines = 64;
  localparam int n_cols    = 21;

  logic                    clk;
  logic                    ext_rst_b;
  bridge_pkg::core_state_t state;
  bridge_pkg::addr_t       addr_in;
  bridge_pkg::data_t       data_in;
  logic                    read_q;
  logic                    write_q;
  logic                    bus_busy_in;
  bridge_pkg::cpu_index_t  ext_cpu_index;
  logic                    ext_next_cpu_q;
  bridge_pkg::cpu_msg_t    ext_cpu_msg_in;
  bridge_pkg::cpu_msg_t    int_cpu_msg_in;
  bridge_pkg::addr_t       base_addr;
  bridge_pkg::addr_t       base_addr_data;
  bridge_pkg::ind_rel_t    cpu_ind_rel;
  logic                    bus_busy_out;
  logic                    disp_online;
  logic                    next_state;
  logic                    rst;
  logic                    ext_rst_e;
  logic                    ext_next_cpu_e;
  logic                    ext_dispatcher_q;
  bridge_pkg::cpu_msg_t    int_cpu_msg_out;
  bridge_pkg::cpu_msg_t    ext_cpu_msg;
  logic                    ext_read_q;
  logic                    ext_write_q;

  // one row per vector with columns as in the data file header
  logic [31:0] vec [0:max_lines-1][0:n_cols-1];
  int          n_lines;
  int          errors;
  logic        loaded;
  logic [31:0] lcg_state;
  logic [31:0] exp_base;
  logic [31:0] exp_base_data;
  logic [31:0] my_idx_model;
  logic [1:0]  rand_rel;

  core_bridge u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // full match is equal and the number alone gives the order
  function automatic logic [1:0] relation_of(logic [31:0] called, logic [31:0] mine);
    if (called == mine) begin
      return bridge_pkg::rel_equal;
    end else if (called[30:0] < mine[30:0]) begin
      return bridge_pkg::rel_less;
    end else begin
      return bridge_pkg::rel_greater;
    end
  endfunction

  task automatic compare_val(string name, logic [31:0] exp_v, logic [31:0] act_v);
    if (act_v !== exp_v) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic load_vectors();
    int    fd;
    int    cnt;
    string line;
    logic [31:0] f [0:n_cols-1];
    fd = $fopen("verif/bridge_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file");
      errors++;
    end else begin
      while (!$feof(fd) && n_lines < max_lines) begin
        if ($fgets(line, fd) != 0) begin
          cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                        f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20]);
          // header and blank lines do not parse
          if (cnt == n_cols) begin
            for (int k = 0; k < n_cols; k++) begin
              vec[n_lines][k] = f[k];
            end
            n_lines++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_line(int i);
    logic [31:0] idx;
    state          = vec[i][1][5:0];
    addr_in        = vec[i][2];
    data_in        = vec[i][3];
    read_q         = vec[i][4][0];
    write_q        = vec[i][5][0];
    bus_busy_in    = vec[i][6][0];
    idx            = vec[i][7];
    ext_next_cpu_q = vec[i][8][0];
    ext_cpu_msg_in = vec[i][9][3:0];
    int_cpu_msg_in = vec[i][10][3:0];
    // launch draws random addresses and the bases follow the header offset
    if (vec[i][0] == 32'd1) begin
      addr_in = next_rand();
      data_in = (vec[i][3] != 32'd0) ? next_rand() : 32'd0;
      exp_base      = addr_in + bridge_pkg::thread_header_space;
      exp_base_data = (data_in == 32'd0) ? exp_base
                                         : data_in + bridge_pkg::thread_header_space;
    end
    // foreign index never shares our own number
    if (vec[i][0] == 32'd2) begin
      idx = next_rand();
      if (idx[30:0] == my_idx_model[30:0]) begin
        idx[0] = ~idx[0];
      end
      rand_rel = relation_of(idx, my_idx_model);
    end
    // index sampled on the edge that announces the reset
    if (vec[i][11] == 32'(bridge_pkg::msg_reset)) begin
      my_idx_model = idx;
    end
    ext_cpu_index = idx;
  endtask

  task automatic verify_line(int i);
    logic [31:0] rel_exp;
    rel_exp = (vec[i][0] == 32'd2) ? 32'(rand_rel) : vec[i][13];
    compare_val("ext_cpu_msg", vec[i][11], 32'(ext_cpu_msg));
    compare_val("int_cpu_msg_out", vec[i][12], 32'(int_cpu_msg_out));
    compare_val("cpu_ind_rel", rel_exp, 32'(cpu_ind_rel));
    compare_val("ext_next_cpu_e", vec[i][14], 32'(ext_next_cpu_e));
    compare_val("disp_online", vec[i][15], 32'(disp_online));
    compare_val("next_state", vec[i][16], 32'(next_state));
    compare_val("rst", vec[i][17], 32'(rst));
    compare_val("ext_rst_e", vec[i][17], 32'(ext_rst_e));
    compare_val("bus_busy_out", vec[i][17], 32'(bus_busy_out));
    compare_val("ext_dispatcher_q", vec[i][18], 32'(ext_dispatcher_q));
    compare_val("ext_read_q", vec[i][19], 32'(ext_read_q));
    compare_val("ext_write_q", vec[i][20], 32'(ext_write_q));
    compare_val("base_addr", exp_base, base_addr);
    compare_val("base_addr_data", exp_base_data, base_addr_data);
  endtask

  // every control output low while in reset
  task automatic expect_idle();
    compare_val("rst", 32'd0, 32'(rst));
    compare_val("ext_rst_e", 32'd0, 32'(ext_rst_e));
    compare_val("bus_busy_out", 32'd0, 32'(bus_busy_out));
    compare_val("disp_online", 32'd0, 32'(disp_online));
    compare_val("next_state", 32'd0, 32'(next_state));
    compare_val("ext_next_cpu_e", 32'd0, 32'(ext_next_cpu_e));
    compare_val("ext_dispatcher_q", 32'd0, 32'(ext_dispatcher_q));
    compare_val("ext_cpu_msg", 32'd0, 32'(ext_cpu_msg));
    compare_val("ext_read_q", 32'd0, 32'(ext_read_q));
    compare_val("ext_write_q", 32'd0, 32'(ext_write_q));
    compare_val("cpu_ind_rel", 32'd0, 32'(cpu_ind_rel));
    compare_val("base_addr", 32'd0, base_addr);
  endtask

  initial begin
    ext_rst_b      = 1'b1;
    state          = 6'h3f;
    addr_in        = '0;
    data_in        = '0;
    read_q         = 1'b0;
    write_q        = 1'b0;
    bus_busy_in    = 1'b0;
    ext_cpu_index  = '0;
    ext_next_cpu_q = 1'b0;
    ext_cpu_msg_in = '0;
    int_cpu_msg_in = '0;
    errors         = 0;
    n_lines        = 0;
    loaded         = 1'b0;
    lcg_state      = 32'd47334;
    exp_base       = '0;
    exp_base_data  = '0;
    my_idx_model   = '0;
    rand_rel       = '0;
    load_vectors();
    loaded = 1'b1;
    repeat (5) begin
      @(negedge clk);
      expect_idle();
    end
    ext_rst_b = 1'b0;
    // results settle by the next falling edge
    for (int i = 0; i < n_lines; i++) begin
      drive_line(i);
      @(negedge clk);
      verify_line(i);
    end
    $display("vectors: %0d  errors: %0d", n_lines, errors);
    if (errors == 0 && n_lines > 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // 40 cycles per vector plus reset and its three-step sequence
  initial begin
    int limit_ns;
    wait (loaded);
    limit_ns = (n_lines * 40 + 5 + 3) * 8;
    #(limit_ns);
    $display("timeout: the vector run did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
